//--- Makefile
VERILATOR ?= verilator
TOP       ?= ramio_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+common
common/bus_pkg.sv
common/uart_pkg.sv
ramio/word_ram.sv
uart/uart_tx.sv
uart/uart_rx.sv
ramio/ramio.sv
testbench/tb_clock.sv
testbench/ramio_sva.sv
testbench/ramio_tb.sv

//--- common/bus_pkg.sv
// types for the core side access bus
// size codes are shared by read_type low bits and write_type
// read_type bit 2 selects sign extension on byte and half-word reads
`default_nettype none

package bus_pkg;

  // byte address from the core
  typedef logic [31:0] addr_t;

  // one data word, also the ram word
  typedef logic [31:0] word_t;

  // one write enable per byte lane, bit 0 is lane 0
  typedef logic [3:0] byte_en_t;

  // bit 2 signed, bits 1:0 size, zero means no read
  typedef logic [2:0] read_type_t;

  // size only, zero means no write
  typedef logic [1:0] write_type_t;

  // access size codes
  localparam logic [1:0] size_byte = 2'b01;
  localparam logic [1:0] size_half = 2'b10;
  localparam logic [1:0] size_word = 2'b11;

  // steered write towards the word ram
  typedef struct packed {
    byte_en_t be;
    word_t    data;
  } ram_wr_t;

endpackage

`default_nettype wire

//--- common/ramio_settings.svh
// build settings for the ramio adapter and its uart
// clocks per bit is kept small so simulation stays short, must be 4 or more
// the word ram index is 8 bits wide, so the depth may not exceed 256
// the three I/O addresses sit at the very top of the byte address space
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

// uart bit period in clk cycles
// same value for transmitter and receiver
`define RAMIO_CLKS_PER_BIT 8

// number of 32-bit words in the on-chip ram
`define RAMIO_RAM_WORDS 256

// led register, write only with a byte store
`define RAMIO_ADDR_LED 32'hFFFF_FFFF

// uart transmit byte, byte access only
`define RAMIO_ADDR_UART_OUT (`RAMIO_ADDR_LED - 32'd1)

// uart receive byte, cleared when read
`define RAMIO_ADDR_UART_IN (`RAMIO_ADDR_LED - 32'd2)

`endif

//--- common/uart_pkg.sv
// types for the 8N1 serial link
// no parity state and no framing error state exist
`default_nettype none

package uart_pkg;

  // one data byte on the line, sent lsb first
  typedef logic [7:0] uart_byte_t;

  // transmitter, done waits for go to fall
  typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_stop, tx_done} tx_state_t;

  // receiver, hold keeps data_ready until the ack
  typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_stop, rx_hold} rx_state_t;

endpackage

`default_nettype wire

//--- ramio/ramio.sv
// memory-mapped I/O adapter: word ram, 4 leds, uart out and uart in
// inputs must be held until data_out_ready, ram accesses take one cycle
// misaligned half-word and word accesses are ignored and read as zero
// I/O addresses take byte accesses only, a tx write while sending restarts
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module ramio (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable,
  input  bus_pkg::read_type_t     read_type,
  input  bus_pkg::write_type_t    write_type,
  input  bus_pkg::addr_t          address,
  input  bus_pkg::word_t          data_in,
  output bus_pkg::word_t          data_out,
  output logic                    data_out_ready,
  output logic [3:0]              led,
  output logic                    uart_tx,
  input  logic                    uart_rx
);

  import bus_pkg::*;
  import uart_pkg::*;

  logic       is_led;
  logic       is_tx;
  logic       is_rx;
  logic       is_io;
  logic       ram_en;
  ram_wr_t    ram_wr;
  word_t      ram_rdata;
  logic       ram_ready;
  uart_byte_t rd_byte;
  logic [7:0] lane_byte;
  logic [15:0] lane_half;
  logic       rd_signed;
  logic       led_wr;
  logic       tx_wr;
  logic       rx_rd;
  // transmit side
  uart_byte_t tx_byte;
  logic       tx_go;
  logic       tx_bsy;
  // go was raised last cycle, bsy not yet valid
  logic       tx_go_new;
  // go dropped for one cycle to abort the frame in flight
  logic       tx_restart;
  // receive side
  uart_byte_t rx_byte;
  uart_byte_t rx_data;
  logic       rx_go;
  logic       rx_ready;

  // address decode
  assign is_led = (address == `RAMIO_ADDR_LED);
  assign is_tx  = (address == `RAMIO_ADDR_UART_OUT);
  assign is_rx  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io  = is_led || is_tx || is_rx;
  assign ram_en = enable && !is_io;

  // I/O answers at once, ram after its read cycle
  assign data_out_ready = is_io ? 1'b1 : ram_ready;

  assign led_wr = enable && is_led && (write_type == size_byte);
  assign tx_wr  = enable && is_tx && (write_type == size_byte);
  assign rx_rd  = enable && is_rx && (read_type[1:0] == size_byte);

  // write lane steering, data is replicated and the enables pick the lanes
  always_comb begin
    ram_wr = '0;
    unique case (write_type)
      size_byte: begin
        ram_wr.be   = byte_en_t'(4'b0001 << address[1:0]);
        ram_wr.data = {4{data_in[7:0]}};
      end
      size_half: begin
        // odd address leaves both enables clear
        if (!address[0]) begin
          ram_wr.be   = address[1] ? 4'b1100 : 4'b0011;
          ram_wr.data = {2{data_in[15:0]}};
        end
      end
      size_word: begin
        if (address[1:0] == 2'b00) begin
          ram_wr.be   = 4'b1111;
          ram_wr.data = data_in;
        end
      end
      default: ;
    endcase
  end

  // read lane select and extension
  always_comb begin
    lane_byte = ram_rdata[{address[1:0], 3'b000} +: 8];
    lane_half = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    rd_signed = read_type[2];
    if (is_rx) begin
      rd_byte = rx_byte;
    end else if (is_tx) begin
      rd_byte = tx_byte;
    end else begin
      rd_byte = lane_byte;
    end
    data_out = '0;
    if (enable) begin
      unique case (read_type[1:0])
        // led is write only and reads as zero
        size_byte: if (!is_led) data_out = {{24{rd_signed && rd_byte[7]}}, rd_byte};
        size_half: begin
          if (!is_io && !address[0]) data_out = {{16{rd_signed && lane_half[15]}}, lane_half};
        end
        size_word: if (!is_io && address[1:0] == 2'b00) data_out = ram_rdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // all leds off
      led        <= 4'b1111;
      tx_byte    <= '0;
      tx_go      <= 1'b0;
      tx_go_new  <= 1'b0;
      tx_restart <= 1'b0;
      rx_byte    <= '0;
      rx_go      <= 1'b1;
    end else begin
      tx_go_new  <= 1'b0;
      tx_restart <= 1'b0;
      // a read empties the rx byte, a pending byte is copied next cycle
      if (rx_rd) begin
        rx_byte <= '0;
      end else if (rx_go && rx_ready) begin
        // copy and ack, an unread byte is overwritten
        rx_byte <= rx_data;
        rx_go   <= 1'b0;
      end
      // ack lasts one cycle
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // stop bit finished, ack the transmitter
      if (tx_go && !tx_bsy && !tx_go_new) begin
        tx_go   <= 1'b0;
        tx_byte <= '0;
      end
      // second half of a restart
      if (tx_restart) begin
        tx_go     <= 1'b1;
        tx_go_new <= 1'b1;
      end
      if (tx_wr) begin
        tx_byte <= data_in[7:0];
        if (tx_go) begin
          tx_go      <= 1'b0;
          tx_restart <= 1'b1;
        end else begin
          tx_go     <= 1'b1;
          tx_go_new <= 1'b1;
        end
      end
      if (led_wr) begin
        led <= data_in[3:0];
      end
    end
  end

  word_ram word_ram_inst (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_wr.be),
    .index (address[9:2]),
    .wdata (ram_wr.data),
    .rdata (ram_rdata),
    .ready (ram_ready)
  );

  uart_tx uart_tx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_byte),
    .go    (tx_go),
    .bsy   (tx_bsy),
    .tx    (uart_tx)
  );

  uart_rx uart_rx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

endmodule

`default_nettype wire

//--- ramio/word_ram.sv
// synchronous word ram, one cycle read latency
// read during write returns the old word
// ready needs en held, it drops in the same cycle as en
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module word_ram (
  input  logic              clk,
  input  logic              en,
  input  bus_pkg::byte_en_t we,
  input  logic [7:0]        index,
  input  bus_pkg::word_t    wdata,
  output bus_pkg::word_t    rdata,
  output logic              ready
);

  import bus_pkg::*;

  word_t mem [`RAMIO_RAM_WORDS];
  // en seen at the last edge
  logic  en_q;

  always_ff @(posedge clk) begin
    if (en) begin
      // only the enabled lanes change
      for (int lane = 0; lane < 4; lane++) begin
        if (we[lane]) mem[index][lane*8 +: 8] <= wdata[lane*8 +: 8];
      end
      rdata <= mem[index];
    end
  end

  always_ff @(posedge clk) begin
    en_q <= en;
  end

  assign ready = en && en_q;

endmodule

`default_nettype wire

//--- testbench/ramio_patterns.txt
# op type address data expected, all fields hex
# op: W write, R read and compare data_out, L compare led, P poll rx until expected
L 0 00000000 00000000 0000000f
W 3 00000000 12345678 00000000
W 3 00000004 cafef00d 00000000
W 3 000003fc 0badbeef 00000000
R 3 00000000 00000000 12345678
R 3 000003fc 00000000 0badbeef
W 1 00000001 000000a5 00000000
W 2 00000006 0000beef 00000000
R 3 00000000 00000000 1234a578
R 3 00000004 00000000 beeff00d
R 5 00000001 00000000 ffffffa5
R 1 00000001 00000000 000000a5
R 5 00000003 00000000 00000012
R 6 00000000 00000000 ffffa578
R 6 00000006 00000000 ffffbeef
R 2 00000006 00000000 0000beef
R 6 00000002 00000000 00001234
W 2 00000005 00001111 00000000
R 3 00000004 00000000 beeff00d
R 2 00000005 00000000 00000000
W 1 ffffffff 0000005a 00000000
L 0 00000000 00000000 0000000a
W 1 fffffffe 000000c3 00000000
R 1 fffffffe 00000000 000000c3
R 1 fffffffd 00000000 00000000
P 1 fffffffd 00000000 000000c3
R 1 fffffffd 00000000 00000000

//--- testbench/ramio_sva.sv
// protocol checks for ramio, attached with bind
// the ram ready check assumes one idle cycle between accesses
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module ramio_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 enable,
  input bus_pkg::read_type_t  read_type,
  input bus_pkg::write_type_t write_type,
  input bus_pkg::addr_t       address,
  input logic                 data_out_ready,
  input logic                 uart_tx
);

  logic ram_addr;

  // anything outside the three I/O addresses goes to the word ram
  assign ram_addr = (address != `RAMIO_ADDR_LED) &&
                    (address != `RAMIO_ADDR_UART_OUT) &&
                    (address != `RAMIO_ADDR_UART_IN);

  // ram is not ready in the cycle enable rises
  ram_ready_late_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ram_addr && $rose(enable)) |-> !data_out_ready
  ) else $error("ram data_out_ready high in the first enable cycle");

  // one cycle later it answers, as long as enable is still held
  ram_ready_follows_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ram_addr && $rose(enable)) |=> (data_out_ready || !enable)
  ) else $error("ram data_out_ready missing one cycle after enable");

  // serial line idles high through reset
  tx_idle_in_reset_a: assert property (
    @(posedge clk) !rst_n |=> uart_tx
  ) else $error("uart_tx not high during reset");

  // an access is a read or a write, never both
  one_direction_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    enable |-> !((write_type != '0) && (read_type != '0))
  ) else $error("read_type and write_type both nonzero");

endmodule

bind ramio ramio_sva ramio_sva_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .enable         (enable),
  .read_type      (read_type),
  .write_type     (write_type),
  .address        (address),
  .data_out_ready (data_out_ready),
  .uart_tx        (uart_tx)
);

`default_nettype wire

//--- testbench/ramio_tb.sv
// testbench for ramio with every access and its expected result taken from the pattern file
// uart_tx is looped back into uart_rx
// each access ends with an idle cycle so ram ready always starts from low
// run from the project root since the pattern path is relative to it
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module ramio_tb;

  import bus_pkg::*;

  localparam string pattern_file  = "testbench/ramio_patterns.txt";
  localparam int    clk_period_ns = 40;
  // rx polls allowed before the looped byte must be there
  localparam int    poll_limit    = 12 * `RAMIO_CLKS_PER_BIT;

  logic        clk;
  logic        rst_n;
  logic        enable;
  read_type_t  read_type;
  write_type_t write_type;
  addr_t       address;
  word_t       data_in;
  word_t       data_out;
  logic        data_out_ready;
  logic [3:0]  led;
  // tx output fed straight back to rx
  logic        serial_loop;

  // pattern columns
  logic [7:0]  ops[$];
  logic [2:0]  types[$];
  addr_t       addrs[$];
  word_t       datas[$];
  word_t       expects[$];

  tb_clock #(.period_ns(clk_period_ns), .reset_cycles(4)) tb_clock_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ramio ramio_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (serial_loop),
    .uart_rx        (serial_loop)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input int line_no);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0d ns: pattern %0d data_out %h, expected %h",
                          $time, line_no, got, exp));
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp, input int line_no);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0d ns: pattern %0d led %b, expected %b",
                          $time, line_no, got, exp));
    end
  endtask

  // lines starting with # are skipped and others hold op, type, address, data, expected
  task automatic load_patterns();
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [2:0]       typ;
    addr_t            addr;
    word_t            data;
    word_t            exp;
    logic [8*256-1:0] rest;
    fd = $fopen(pattern_file, "r");
    if (fd == 0) begin
      abort_run("could not open the pattern file");
    end else begin
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
        if (op == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h", typ, addr, data, exp);
          if (code != 4) begin
            abort_run("pattern file has a line with missing fields");
          end else begin
            ops.push_back(op);
            types.push_back(typ);
            addrs.push_back(addr);
            datas.push_back(data);
            expects.push_back(exp);
          end
        end
        code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
    end
  endtask

  // one bus access with inputs held until data_out_ready and then dropped
  task automatic run_access(input read_type_t rt, input write_type_t wt, input addr_t addr,
                            input word_t wdata, output word_t rdata);
    @(posedge clk);
    enable     <= 1'b1;
    read_type  <= rt;
    write_type <= wt;
    address    <= addr;
    data_in    <= wdata;
    // sample away from the rising edge
    do begin
      @(negedge clk);
    end while (data_out_ready !== 1'b1);
    rdata = data_out;
    @(posedge clk);
    enable     <= 1'b0;
    read_type  <= '0;
    write_type <= '0;
  endtask

  task automatic run_pattern(input int n);
    word_t got;
    int    polls;
    case (ops[n])
      "W": run_access('0, write_type_t'(types[n][1:0]), addrs[n], datas[n], got);
      "R": begin
        run_access(read_type_t'(types[n]), '0, addrs[n], '0, got);
        check_word(got, expects[n], n);
      end
      "L": begin
        @(negedge clk);
        check_led(led, expects[n][3:0], n);
      end
      "P": begin
        // rx reads zero until the looped byte lands
        polls = 0;
        run_access(read_type_t'(types[n]), '0, addrs[n], '0, got);
        while (got !== expects[n]) begin
          if (got !== '0) begin
            check_word(got, expects[n], n);
          end
          polls++;
          if (polls > poll_limit) begin
            abort_run($sformatf("received byte never showed up in pattern %0d", n));
          end
          run_access(read_type_t'(types[n]), '0, addrs[n], '0, got);
        end
      end
      default: abort_run($sformatf("unknown op %c in pattern %0d", ops[n], n));
    endcase
  endtask

  task automatic watchdog(input longint limit_ns);
    #(limit_ns);
    abort_run("timeout, the run did not finish in time");
  endtask

  initial begin
    longint limit_ns;
    enable     = 1'b0;
    read_type  = '0;
    write_type = '0;
    address    = '0;
    data_in    = '0;
    load_patterns();
    // 12 bit times plus 20 cycles for each line
    limit_ns = longint'(ops.size()) * longint'(12 * `RAMIO_CLKS_PER_BIT + 20) *
               longint'(clk_period_ns);
    fork
      watchdog(limit_ns);
    join_none
    wait (rst_n === 1'b1);
    for (int n = 0; n < ops.size(); n++) begin
      run_pattern(n);
    end
    @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// clock and reset source for the ramio testbench
// reset is synchronous and held low across the first reset_cycles rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  // free running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // release on a rising edge like any other synchronous input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
// 8N1 serial receiver with two flop input sync
// bits are sampled at mid-bit, a start glitch shorter than half a bit is dropped
// no framing check, data_ready is held until go falls
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module uart_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  input  logic                 go,
  output uart_pkg::uart_byte_t data,
  output logic                 data_ready
);

  import uart_pkg::*;

  localparam int unsigned cw = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [cw-1:0] last_cnt = cw'(`RAMIO_CLKS_PER_BIT - 1);
  // one cycle is spent in idle finding the edge
  localparam logic [cw-1:0] half_cnt = cw'(`RAMIO_CLKS_PER_BIT / 2 - 1);

  logic       rx_meta;
  logic       rx_sync;
  rx_state_t  state;
  logic [cw-1:0] clk_cnt;
  logic [2:0] bit_idx;

  // line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= rx_idle;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
      unique case (state)
        rx_idle: begin
          clk_cnt <= '0;
          // falling start edge
          if (!rx_sync) state <= rx_start;
        end
        rx_start: begin
          if (clk_cnt == half_cnt) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // still low at mid-bit, else a glitch
            state   <= rx_sync ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            // lsb first, shift in from the top
            data    <= {rx_sync, data[7:1]};
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        rx_stop: begin
          // mid stop bit, line value is not checked
          if (clk_cnt == last_cnt) begin
            clk_cnt <= '0;
            state   <= rx_hold;
          end
        end
        rx_hold: begin
          clk_cnt <= '0;
          if (go) begin
            data_ready <= 1'b1;
          end else if (data_ready) begin
            // ack seen
            data_ready <= 1'b0;
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
// 8N1 serial transmitter, idle line is high
// bsy rises one cycle after go and falls when the stop bit ends
// go falling mid frame aborts it, a new go then sends from the start
`timescale 1ns/1ps
`default_nettype none
`include "ramio_settings.svh"

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_byte_t data,
  input  logic                 go,
  output logic                 bsy,
  output logic                 tx
);

  import uart_pkg::*;

  localparam int unsigned cw = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [cw-1:0] last_cnt = cw'(`RAMIO_CLKS_PER_BIT - 1);

  tx_state_t  state;
  logic [cw-1:0] clk_cnt;
  logic [2:0] bit_idx;
  // byte taken at start, shifted out lsb first
  uart_byte_t shreg;
  logic       bit_end;

  assign bit_end = (clk_cnt == last_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= tx_idle;
      tx      <= 1'b1;
      bsy     <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!go && state != tx_idle) begin
      // ack after done, or abort of a frame in flight
      state <= tx_idle;
      tx    <= 1'b1;
      bsy   <= 1'b0;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      unique case (state)
        tx_idle: begin
          clk_cnt <= '0;
          if (go) begin
            shreg <= data;
            bsy   <= 1'b1;
            // start bit
            tx    <= 1'b0;
            state <= tx_start;
          end
        end
        tx_start: begin
          if (bit_end) begin
            tx      <= shreg[0];
            shreg   <= shreg >> 1;
            bit_idx <= '0;
            state   <= tx_data;
          end
        end
        tx_data: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              // stop bit
              tx    <= 1'b1;
              state <= tx_stop;
            end else begin
              tx      <= shreg[0];
              shreg   <= shreg >> 1;
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        tx_stop: begin
          if (bit_end) begin
            bsy   <= 1'b0;
            state <= tx_done;
          end
        end
        // left only through go falling
        tx_done: ;
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire
